//--- flist.f
hw/clk_meter_pkg.sv
hw/meter_ctrl.sv
hw/event_counter.sv
hw/result_check.sv
hw/clk_meter_top.sv
verif/tb_clk_gen.sv
verif/clk_meter_asserts.sv
verif/tb_clk_meter.sv

//--- Bender.yml
package:
  name: clk_meter

sources:
  - files:
      - hw/clk_meter_pkg.sv
      - hw/meter_ctrl.sv
      - hw/event_counter.sv
      - hw/result_check.sv
      - hw/clk_meter_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/clk_meter_asserts.sv
      - verif/tb_clk_meter.sv

//--- verif/tb_clk_meter.sv
//----------------------------
// Clock meter testbench
// Two measured clocks, random windows
// and limits, timeout and report
//----------------------------
`default_nettype none

module tb_clk_meter;

   localparam int NUM_MEAS  = 12;
   localparam int OVF_IDX   = 6;
   localparam int BUSY_IDX  = 3;
   localparam int CNTR_PER  = 8;
   localparam int MEAS_PER0 = 6;
   localparam int MEAS_PER1 = 10;
   localparam int CNT_MAX   = (1 << clk_meter_pkg::CNT_W) - 1;

   logic clk_cntr;
   logic sync_reset_cntr;
   logic [clk_meter_pkg::NUM_CH-1:0] meas_clk;
   logic start;
   logic [clk_meter_pkg::WIN_W-1:0] window;
   logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] lo_lim;
   logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] hi_lim;
   logic busy;
   logic result_valid;
   logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] count;
   logic [clk_meter_pkg::NUM_CH-1:0] ovf;
   logic [clk_meter_pkg::NUM_CH-1:0] in_range;

   int win_len [NUM_MEAS];
   int err_cnt     = 0;
   int cycle_cnt   = 0;
   int cycle_limit = 0;

   tb_clk_gen u_clk_gen (
      .clk_cntr_o        (clk_cntr),
      .sync_reset_cntr_o (sync_reset_cntr)
   );

   clk_meter_top DUT (
      .clk_cntr        (clk_cntr),
      .sync_reset_cntr (sync_reset_cntr),
      .meas_clk_i      (meas_clk),
      .start_i         (start),
      .window_i        (window),
      .lo_lim_i        (lo_lim),
      .hi_lim_i        (hi_lim),
      .busy_o          (busy),
      .result_valid_o  (result_valid),
      .count_o         (count),
      .ovf_o           (ovf),
      .in_range_o      (in_range)
   );

   // Measured clocks
   initial meas_clk = '0;
   always #(MEAS_PER0 / 2) meas_clk[0] = ~meas_clk[0];
   always #(MEAS_PER1 / 2) meas_clk[1] = ~meas_clk[1];

   // Run limit in clk_cntr cycles
   always @(posedge clk_cntr) begin
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d clk_cntr cycles", cycle_limit);
         $display("Errors: %0d testbench, %0d assertion", err_cnt, DUT.u_asserts.fail_cnt);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [clk_meter_pkg::CNT_W-1:0] clamp_cnt(input int v);
      if (v < 0) begin
         return '0;
      end
      if (v > CNT_MAX) begin
         return clk_meter_pkg::CNT_W'(CNT_MAX);
      end
      return clk_meter_pkg::CNT_W'(v);
   endfunction

   // Limits around the ideal count or clear above it
   // Past the counter range the limits span every count, so only the flag decides
   task automatic set_limits(input int ch, input int ideal, input bit bracket);
      int lo;
      int hi;
      if (ideal > CNT_MAX) begin
         lo = 0;
         hi = CNT_MAX;
      end else if (bracket) begin
         lo = ideal - 8 - int'($urandom % 30);
         hi = ideal + 8 + int'($urandom % 30);
      end else begin
         lo = ideal + 12 + int'($urandom % 60);
         hi = lo + int'($urandom % 100);
      end
      lo_lim[ch] = clamp_cnt(lo);
      hi_lim[ch] = clamp_cnt(hi);
   endtask

   task automatic run_measure(input int idx);
      int waited;
      @(negedge clk_cntr);
      window = clk_meter_pkg::WIN_W'(win_len[idx]);
      set_limits(0, win_len[idx] * CNTR_PER / MEAS_PER0, idx % 2 == 0);
      set_limits(1, win_len[idx] * CNTR_PER / MEAS_PER1, idx % 2 == 1);
      start = 1'b1;
      @(negedge clk_cntr);
      start = 1'b0;
      // Extra start mid measurement that the DUT must ignore
      if (idx == BUSY_IDX) begin
         repeat (20) @(negedge clk_cntr);
         start = 1'b1;
         @(negedge clk_cntr);
         start = 1'b0;
      end
      waited = 0;
      while (!result_valid && waited < win_len[idx] + 100) begin
         @(negedge clk_cntr);
         waited++;
      end
      if (!result_valid) begin
         $display("Measurement %0d did not complete within %0d cycles", idx, waited);
         err_cnt++;
      end
   endtask

   initial begin
      int total;
      void'($urandom(32'ha596));
      start  = 1'b0;
      window = '0;
      lo_lim = '0;
      hi_lim = '0;
      // Random windows with one overflow run and a short run after it
      for (int i = 0; i < NUM_MEAS; i++) begin
         win_len[i] = 200 + int'($urandom % 2700);
         if (i == OVF_IDX) begin
            win_len[i] = 3500;
         end
         if (i == OVF_IDX + 1) begin
            win_len[i] = 300;
         end
         cycle_limit += win_len[i] + 100;
      end
      @(posedge sync_reset_cntr);
      repeat (4) @(negedge clk_cntr);
      for (int i = 0; i < NUM_MEAS; i++) begin
         run_measure(i);
      end
      repeat (4) @(negedge clk_cntr);
      total = err_cnt + DUT.u_asserts.fail_cnt;
      $display("Errors: %0d testbench, %0d assertion", err_cnt, DUT.u_asserts.fail_cnt);
      if (total == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/clk_meter_asserts.sv
//----------------------------
// Clock meter assertions
// Checks start and valid timing,
// counts, overflow and verdicts
//----------------------------
`default_nettype none

module clk_meter_asserts #(
   parameter int MEAS_PER0 = 6,
   parameter int MEAS_PER1 = 10
) (
   input wire logic                                                   clk_cntr,
   input wire logic                                                   sync_reset_cntr,
   input wire logic                                                   start_i,
   input wire logic [clk_meter_pkg::WIN_W-1:0]                        window_i,
   input wire logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] lo_lim_i,
   input wire logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] hi_lim_i,
   input wire logic                                                   busy_i,
   input wire logic                                                   result_valid_i,
   input wire logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] count_i,
   input wire logic [clk_meter_pkg::NUM_CH-1:0]                       ovf_i,
   input wire logic [clk_meter_pkg::NUM_CH-1:0]                       in_range_i
);

   localparam int CNTR_PER   = 8;
   localparam int TOL        = 4;
   localparam int NO_OVF_MAX = 4000;
   localparam int CNT_MAX    = (1 << clk_meter_pkg::CNT_W) - 1;

   // Failure count, read by the testbench top
   int fail_cnt = 0;

   logic seen_start;
   logic pending;
   logic accept;
   logic [clk_meter_pkg::WIN_W-1:0] win_q;
   logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] lo_q;
   logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] hi_q;

   // Start taken only when idle, also on the valid cycle itself
   assign accept = start_i && !busy_i && (!pending || result_valid_i);

   // Model of the measurement in flight
   always_ff @(posedge clk_cntr or negedge sync_reset_cntr) begin
      if (!sync_reset_cntr) begin
         seen_start <= 1'b0;
         pending    <= 1'b0;
         win_q      <= '0;
         lo_q       <= '0;
         hi_q       <= '0;
      end else begin
         if (start_i) begin
            seen_start <= 1'b1;
         end
         if (accept) begin
            pending <= 1'b1;
            win_q   <= window_i;
            lo_q    <= lo_lim_i;
            hi_q    <= hi_lim_i;
         end else if (result_valid_i) begin
            pending <= 1'b0;
         end
      end
   end

   //----------------------------
   // Handshake timing
   //----------------------------
   a_quiet_before_start: assert property (@(posedge clk_cntr) disable iff (!sync_reset_cntr)
      !seen_start |-> !busy_i && !result_valid_i)
      else begin
         fail_cnt++;
         $error("ERROR %0t: busy or valid high before the first start", $time);
      end

   a_valid_one_cycle: assert property (@(posedge clk_cntr) disable iff (!sync_reset_cntr)
      result_valid_i |=> !result_valid_i)
      else begin
         fail_cnt++;
         $error("ERROR %0t: result valid longer than one cycle", $time);
      end

   a_valid_not_busy: assert property (@(posedge clk_cntr) disable iff (!sync_reset_cntr)
      result_valid_i |-> !busy_i)
      else begin
         fail_cnt++;
         $error("ERROR %0t: busy still high at result valid", $time);
      end

   // No pulse without an accepted start
   a_valid_has_start: assert property (@(posedge clk_cntr) disable iff (!sync_reset_cntr)
      result_valid_i |-> pending)
      else begin
         fail_cnt++;
         $error("ERROR %0t: result valid without an accepted start", $time);
      end

   //----------------------------
   // Per channel results
   //----------------------------
   for (genvar ch = 0; ch < clk_meter_pkg::NUM_CH; ch++) begin : g_ch
      localparam int PER = (ch == 0) ? MEAS_PER0 : MEAS_PER1;

      // Ideal edge count over the recorded window
      int ideal;

      always_comb ideal = int'(win_q) * CNTR_PER / PER;

      a_count: assert property (@(posedge clk_cntr) disable iff (!sync_reset_cntr)
         result_valid_i && ideal < NO_OVF_MAX |-> !ovf_i[ch] &&
            int'(count_i[ch]) >= ideal - TOL && int'(count_i[ch]) <= ideal + TOL)
         else begin
            fail_cnt++;
            $error("ERROR %0t: ch%0d count %0d ovf %0b, ideal %0d", $time, ch,
                   count_i[ch], ovf_i[ch], ideal);
         end

      a_overflow: assert property (@(posedge clk_cntr) disable iff (!sync_reset_cntr)
         result_valid_i && ideal > CNT_MAX + TOL |-> ovf_i[ch])
         else begin
            fail_cnt++;
            $error("ERROR %0t: ch%0d overflow missing, ideal %0d", $time, ch, ideal);
         end

      a_verdict: assert property (@(posedge clk_cntr) disable iff (!sync_reset_cntr)
         result_valid_i |-> in_range_i[ch] ==
            (count_i[ch] >= lo_q[ch] && count_i[ch] <= hi_q[ch] && !ovf_i[ch]))
         else begin
            fail_cnt++;
            $error("ERROR %0t: ch%0d verdict %0b for count %0d, limits %0d..%0d", $time,
                   ch, in_range_i[ch], count_i[ch], lo_q[ch], hi_q[ch]);
         end
   end

endmodule

bind clk_meter_top clk_meter_asserts #(
   .MEAS_PER0 (6),
   .MEAS_PER1 (10)
) u_asserts (
   .clk_cntr        (clk_cntr),
   .sync_reset_cntr (sync_reset_cntr),
   .start_i         (start_i),
   .window_i        (window_i),
   .lo_lim_i        (lo_lim_i),
   .hi_lim_i        (hi_lim_i),
   .busy_i          (busy_o),
   .result_valid_i  (result_valid_o),
   .count_i         (count_o),
   .ovf_i           (ovf_o),
   .in_range_i      (in_range_o)
);

`default_nettype wire

//--- verif/tb_clk_gen.sv
//----------------------------
// Testbench clock and reset
// Makes clk_cntr and the active low
// sync_reset_cntr
//----------------------------
`default_nettype none

module tb_clk_gen (
   output logic clk_cntr_o,
   output logic sync_reset_cntr_o
);

   localparam int PERIOD  = 8;
   localparam int RST_CYC = 5;

   initial begin
      clk_cntr_o = 1'b0;
      forever #(PERIOD / 2) clk_cntr_o = ~clk_cntr_o;
   end

   // Reset low for the first cycles, released on a falling edge
   initial begin
      sync_reset_cntr_o = 1'b0;
      repeat (RST_CYC) @(posedge clk_cntr_o);
      @(negedge clk_cntr_o);
      sync_reset_cntr_o = 1'b1;
   end

endmodule

`default_nettype wire

//--- hw/clk_meter_top.sv
//----------------------------
// Clock frequency meter top
// Controller, one event counter per
// measured clock and result check
//----------------------------
`default_nettype none

module clk_meter_top (
   input  wire logic                                                   clk_cntr,
   input  wire logic                                                   sync_reset_cntr,
   input  wire logic [clk_meter_pkg::NUM_CH-1:0]                       meas_clk_i,
   input  wire logic                                                   start_i,
   input  wire logic [clk_meter_pkg::WIN_W-1:0]                        window_i,
   input  wire logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] lo_lim_i,
   input  wire logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] hi_lim_i,
   output logic                                                        busy_o,
   output logic                                                        result_valid_o,
   output logic      [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] count_o,
   output logic      [clk_meter_pkg::NUM_CH-1:0]                       ovf_o,
   output logic      [clk_meter_pkg::NUM_CH-1:0]                       in_range_o
);

   //----------------------------
   // Interconnect
   //----------------------------

   // Controller levels to all counters
   logic cntr_clear;
   logic cntr_run;

   // Per channel run status, in each measured clock
   logic [clk_meter_pkg::NUM_CH-1:0] cntr_status;

   // Completion strobe to result check
   logic meas_done;

   // Raw counter outputs
   logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] cnt;
   logic [clk_meter_pkg::NUM_CH-1:0]                           cnt_ovf;

   // Sequencer
   meter_ctrl u_meter_ctrl (
      .clk_cntr        (clk_cntr),
      .sync_reset_cntr (sync_reset_cntr),
      .start_i         (start_i),
      .window_i        (window_i),
      .cntr_status_i   (cntr_status),
      .cntr_clear_o    (cntr_clear),
      .cntr_run_o      (cntr_run),
      .meas_done_o     (meas_done),
      .busy_o          (busy_o)
   );

   // One counter per measured clock
   for (genvar ch = 0; ch < clk_meter_pkg::NUM_CH; ch++) begin : g_ch
      event_counter u_event_counter (
         .clk_cntr        (clk_cntr),
         .sync_reset_cntr (sync_reset_cntr),
         .meas_clk_i      (meas_clk_i[ch]),
         .cntr_clear_i    (cntr_clear),
         .cntr_run_i      (cntr_run),
         .count_o         (cnt[ch]),
         .ovf_o           (cnt_ovf[ch]),
         .cntr_status_o   (cntr_status[ch])
      );
   end

   // Result latch and verdicts
   result_check u_result_check (
      .clk_cntr        (clk_cntr),
      .sync_reset_cntr (sync_reset_cntr),
      .meas_done_i     (meas_done),
      .count_i         (cnt),
      .ovf_i           (cnt_ovf),
      .lo_lim_i        (lo_lim_i),
      .hi_lim_i        (hi_lim_i),
      .count_o         (count_o),
      .ovf_o           (ovf_o),
      .in_range_o      (in_range_o),
      .result_valid_o  (result_valid_o)
   );

endmodule

`default_nettype wire

//--- hw/result_check.sv
//----------------------------
// Result check
// Latches counts and overflow flags
// and judges each count against
// its low and high limits
//----------------------------
`default_nettype none

module result_check (
   input  wire logic                                                   clk_cntr,
   input  wire logic                                                   sync_reset_cntr,
   input  wire logic                                                   meas_done_i,
   input  wire logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] count_i,
   input  wire logic [clk_meter_pkg::NUM_CH-1:0]                       ovf_i,
   input  wire logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] lo_lim_i,
   input  wire logic [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] hi_lim_i,
   output logic      [clk_meter_pkg::NUM_CH-1:0][clk_meter_pkg::CNT_W-1:0] count_o,
   output logic      [clk_meter_pkg::NUM_CH-1:0]                       ovf_o,
   output logic      [clk_meter_pkg::NUM_CH-1:0]                       in_range_o,
   output logic                                                        result_valid_o
);

   //----------------------------
   // Range verdict
   //----------------------------

   // Per channel verdict from the live counter values
   logic [clk_meter_pkg::NUM_CH-1:0] verdict;

   always_comb begin
      for (int ch = 0; ch < clk_meter_pkg::NUM_CH; ch++) begin
         // Inside limits and no wrap
         verdict[ch] = (count_i[ch] >= lo_lim_i[ch]) &&
                       (count_i[ch] <= hi_lim_i[ch]) &&
                       !ovf_i[ch];
      end
   end

   //----------------------------
   // Result registers
   //----------------------------

   // Counters are stopped while meas_done_i is high
   always_ff @(posedge clk_cntr) begin
      if (meas_done_i) begin
         count_o    <= count_i;
         ovf_o      <= ovf_i;
         in_range_o <= verdict;
      end
   end

   // Valid one cycle after the latch strobe
   always_ff @(posedge clk_cntr or negedge sync_reset_cntr) begin
      if (!sync_reset_cntr) begin
         result_valid_o <= 1'b0;
      end else begin
         result_valid_o <= meas_done_i;
      end
   end

endmodule

`default_nettype wire

//--- hw/event_counter.sv
//----------------------------
// Event counter
// Counts edges of one measured clock
// through a gated clock, with sticky
// overflow and status back to clk_cntr
//----------------------------
`default_nettype none

module event_counter (
   input  wire logic                            clk_cntr,
   input  wire logic                            sync_reset_cntr,
   input  wire logic                            meas_clk_i,
   input  wire logic                            cntr_clear_i,
   input  wire logic                            cntr_run_i,
   output logic [clk_meter_pkg::CNT_W-1:0]      count_o,
   output logic                                 ovf_o,
   output logic                                 cntr_status_o
);

   //----------------------------
   // Internal signals
   //----------------------------

   // Clear level registered in clk_cntr
   logic clear_q;

   // Async reset source for the counting domain
   logic clr_rst_n;

   // Local reset synchronizer and its output
   logic [clk_meter_pkg::SYNC_STAGES-1:0] rst_sync;
   logic                                  meas_rst_n;

   // Run level synchronizer and its output
   logic [clk_meter_pkg::SYNC_STAGES-1:0] run_sync;
   logic                                  run_meas;

   // Clock gate enable latch and gated clock
   logic en_latch;
   logic gclk;

   // Glitch free clear source
   always_ff @(posedge clk_cntr or negedge sync_reset_cntr) begin
      if (!sync_reset_cntr) begin
         clear_q <= 1'b1;
      end else begin
         clear_q <= cntr_clear_i;
      end
   end

   assign clr_rst_n = ~clear_q;

   //----------------------------
   // Measured clock domain
   //----------------------------

   // Reset asserts at once and releases on meas_clk_i
   always_ff @(posedge meas_clk_i or negedge clr_rst_n) begin
      if (!clr_rst_n) begin
         rst_sync <= '0;
      end else begin
         rst_sync <= {rst_sync[clk_meter_pkg::SYNC_STAGES-2:0], 1'b1};
      end
   end

   assign meas_rst_n = rst_sync[clk_meter_pkg::SYNC_STAGES-1];

   // Run level into the measured clock
   always_ff @(posedge meas_clk_i or negedge meas_rst_n) begin
      if (!meas_rst_n) begin
         run_sync <= '0;
      end else begin
         run_sync <= {run_sync[clk_meter_pkg::SYNC_STAGES-2:0], cntr_run_i};
      end
   end

   assign run_meas = run_sync[clk_meter_pkg::SYNC_STAGES-1];

   // Status is the synchronized run level
   assign cntr_status_o = run_meas;

   // Enable latch transparent while clock is low
   always_latch begin
      if (!meas_clk_i) begin
         en_latch = run_meas;
      end
   end

   assign gclk = meas_clk_i & en_latch;

   // Edge counter
   // Wraps to zero past all ones and keeps counting
   always_ff @(posedge gclk or negedge meas_rst_n) begin
      if (!meas_rst_n) begin
         count_o <= '0;
         ovf_o   <= 1'b0;
      end else begin
         // Sticky until the next clear
         if (&count_o) begin
            ovf_o <= 1'b1;
         end
         count_o <= count_o + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hw/meter_ctrl.sv
//----------------------------
// Meter controller
// Sequences clear, counting window,
// drain and completion strobe in
// the clk_cntr domain
//----------------------------
`default_nettype none

module meter_ctrl (
   input  wire logic                               clk_cntr,
   input  wire logic                               sync_reset_cntr,
   input  wire logic                               start_i,
   input  wire logic [clk_meter_pkg::WIN_W-1:0]    window_i,
   input  wire logic [clk_meter_pkg::NUM_CH-1:0]   cntr_status_i,
   output logic                                    cntr_clear_o,
   output logic                                    cntr_run_o,
   output logic                                    meas_done_o,
   output logic                                    busy_o
);

   //----------------------------
   // Local constants
   //----------------------------

   // Clear level drops after this hold count
   localparam logic [clk_meter_pkg::CLR_W-1:0] CLR_DROP =
      clk_meter_pkg::CLR_W'(clk_meter_pkg::CLEAR_CYC - 1);

   // Last cycle of the clear phase
   // Leaves room for the counters' reset synchronizers to release
   localparam logic [clk_meter_pkg::CLR_W-1:0] CLR_LAST =
      clk_meter_pkg::CLR_W'(2 * clk_meter_pkg::CLEAR_CYC - 1);

   //----------------------------
   // Internal signals
   //----------------------------
   clk_meter_pkg::ctrl_state_e state;

   // Clear phase cycle counter
   logic [clk_meter_pkg::CLR_W-1:0] hold_cnt;

   // Remaining window cycles
   logic [clk_meter_pkg::WIN_W-1:0] win_cnt;

   // Status synchronizers, one bit per channel per stage
   logic [clk_meter_pkg::SYNC_STAGES-1:0][clk_meter_pkg::NUM_CH-1:0] status_sync;

   // Every counter reports stopped
   logic all_stopped;

   // Bring counter run status back into clk_cntr
   always_ff @(posedge clk_cntr or negedge sync_reset_cntr) begin
      if (!sync_reset_cntr) begin
         status_sync <= '0;
      end else begin
         status_sync <= {status_sync[clk_meter_pkg::SYNC_STAGES-2:0], cntr_status_i};
      end
   end

   assign all_stopped = ~|status_sync[clk_meter_pkg::SYNC_STAGES-1];

   //----------------------------
   // Sequencer FSM
   //----------------------------
   // Outputs are registered and change with the state
   always_ff @(posedge clk_cntr or negedge sync_reset_cntr) begin
      if (!sync_reset_cntr) begin
         state        <= clk_meter_pkg::IDLE;
         hold_cnt     <= '0;
         win_cnt      <= '0;
         busy_o       <= 1'b0;
         meas_done_o  <= 1'b0;
         cntr_run_o   <= 1'b0;
         // Counters held in reset until first measurement
         cntr_clear_o <= 1'b1;
      end else begin
         // Done strobe is a single cycle
         meas_done_o <= 1'b0;
         case (state)
            clk_meter_pkg::IDLE: begin
               // Start ignored anywhere else
               if (start_i) begin
                  state        <= clk_meter_pkg::CLEAR;
                  busy_o       <= 1'b1;
                  cntr_clear_o <= 1'b1;
                  hold_cnt     <= '0;
                  // Window length sampled here
                  win_cnt      <= window_i;
               end
            end
            clk_meter_pkg::CLEAR: begin
               if (hold_cnt != CLR_LAST) begin
                  hold_cnt <= hold_cnt + 1'b1;
               end
               // End of clear hold
               if (hold_cnt == CLR_DROP) begin
                  cntr_clear_o <= 1'b0;
               end
               // Margin done and counters idle
               if (hold_cnt == CLR_LAST && all_stopped) begin
                  state      <= clk_meter_pkg::RUN;
                  cntr_run_o <= 1'b1;
               end
            end
            clk_meter_pkg::RUN: begin
               // Run stays high for exactly the window length
               if (win_cnt <= clk_meter_pkg::WIN_W'(1)) begin
                  state      <= clk_meter_pkg::DRAIN;
                  cntr_run_o <= 1'b0;
               end else begin
                  win_cnt <= win_cnt - 1'b1;
               end
            end
            clk_meter_pkg::DRAIN: begin
               // Wait for every channel to confirm stop
               if (all_stopped) begin
                  state       <= clk_meter_pkg::DONE;
                  meas_done_o <= 1'b1;
                  busy_o      <= 1'b0;
               end
            end
            clk_meter_pkg::DONE: begin
               state <= clk_meter_pkg::IDLE;
            end
            default: begin
               state <= clk_meter_pkg::IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/clk_meter_pkg.sv
//----------------------------
// Clock frequency meter package
// Widths, channel count and the
// controller state encoding
//----------------------------
`default_nettype none

package clk_meter_pkg;

   //----------------------------
   // Channel and width settings
   //----------------------------

   // Number of measured clocks
   localparam int NUM_CH = 2;

   // Event counter width per channel
   localparam int CNT_W = 12;

   // Window length input width, in clk_cntr cycles
   localparam int WIN_W = 16;

   //----------------------------
   // Timing settings
   //----------------------------

   // Cycles the clear level is held high
   localparam int CLEAR_CYC = 4;

   // Depth of every synchronizer chain
   localparam int SYNC_STAGES = 2;

   // Clear phase counter width
   // Covers the hold plus an equal release margin
   localparam int CLR_W = $clog2(2 * CLEAR_CYC);

   //----------------------------
   // Controller states
   //----------------------------
   typedef enum logic [2:0] {
      IDLE  = 3'd0,
      CLEAR = 3'd1,
      RUN   = 3'd2,
      DRAIN = 3'd3,
      DONE  = 3'd4
   } ctrl_state_e;

endpackage

`default_nettype wire
